/* verilog/mpu_pkg.sv */
// Shared types and constants for the data-side memory protection block
// Also holds the fixed PMA region table
`default_nettype none

package mpu_pkg;

  ////////////////////
  // Plain vector types
  ////////////////////

  // Byte address and data of a transfer
  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;

  // PMP address CSR, byte address shifted right by 2
  typedef logic [31:0] pmp_addr_t;

  // PMP config byte: R bit 0, W bit 1, X bit 2, mode bits 4:3, L bit 7
  typedef logic [7:0] pmp_cfg_t;

  // Bus memory type: bit 0 bufferable, bit 1 cacheable
  typedef logic [1:0] memtype_t;

  // Config byte field positions
  localparam int unsigned PMP_CFG_R_BIT = 0;
  localparam int unsigned PMP_CFG_W_BIT = 1;
  localparam int unsigned PMP_CFG_L_BIT = 7;

  ////////////////////
  // Enums
  ////////////////////

  typedef enum logic [1:0] {
    PRIV_U = 2'b00,
    PRIV_M = 2'b11
  } priv_lvl_e;

  // NAPOT decodes like OFF in this block
  typedef enum logic [1:0] {
    PMP_OFF   = 2'b00,
    PMP_TOR   = 2'b01,
    PMP_NA4   = 2'b10,
    PMP_NAPOT = 2'b11
  } pmp_mode_e;

  typedef enum logic [1:0] {
    PMP_ACC_READ  = 2'b00,
    PMP_ACC_WRITE = 2'b01
  } pmp_req_e;

  typedef enum logic [1:0] {
    MPU_OK       = 2'b00,
    MPU_RE_FAULT = 2'b01,
    MPU_WR_FAULT = 2'b10
  } mpu_status_e;

  typedef enum logic [2:0] {
    MPU_IDLE,
    MPU_RE_ERR_WAIT,
    MPU_WR_ERR_WAIT,
    MPU_RE_ERR_RESP,
    MPU_WR_ERR_RESP
  } mpu_state_e;

  ////////////////////
  // PMA region table
  ////////////////////

  // MAIN: cacheable and bufferable, atomics allowed
  localparam addr_t    PMA_MAIN_BASE    = 32'h0000_0000;
  localparam addr_t    PMA_MAIN_SIZE    = 32'h0001_0000;
  localparam memtype_t PMA_MAIN_MEMTYPE = 2'b11;
  localparam logic     PMA_MAIN_ATOMIC  = 1'b1;

  // IO: strongly ordered, no atomics
  localparam addr_t    PMA_IO_BASE      = 32'h1000_0000;
  localparam addr_t    PMA_IO_SIZE      = 32'h0000_1000;
  localparam memtype_t PMA_IO_MEMTYPE   = 2'b00;
  localparam logic     PMA_IO_ATOMIC    = 1'b0;

  // BUF: bufferable only, no atomics
  localparam addr_t    PMA_BUF_BASE     = 32'h2000_0000;
  localparam addr_t    PMA_BUF_SIZE     = 32'h0000_1000;
  localparam memtype_t PMA_BUF_MEMTYPE  = 2'b01;
  localparam logic     PMA_BUF_ATOMIC   = 1'b0;

endpackage

`default_nettype wire

/* verilog/pma_check.sv */
// PMA decode for the data side
// Maps an address onto the fixed region table, gives error and memory type
`timescale 1ns/1ps
`default_nettype none

module pma_check (
  input  wire  mpu_pkg::addr_t    addr_i,
  input  wire                     atomic_i,
  output logic                    pma_err_o,
  output mpu_pkg::memtype_t       pma_memtype_o
);

  logic hit_main;
  logic hit_io;
  logic hit_buf;

  // Offset compare, wraps below base so one unsigned test covers both bounds
  assign hit_main = (addr_i - mpu_pkg::PMA_MAIN_BASE) < mpu_pkg::PMA_MAIN_SIZE;
  assign hit_io   = (addr_i - mpu_pkg::PMA_IO_BASE)   < mpu_pkg::PMA_IO_SIZE;
  assign hit_buf  = (addr_i - mpu_pkg::PMA_BUF_BASE)  < mpu_pkg::PMA_BUF_SIZE;

  always_comb begin
    // Unmapped by default
    pma_err_o     = 1'b1;
    pma_memtype_o = 2'b00;

    if (hit_main) begin
      pma_err_o     = atomic_i && !mpu_pkg::PMA_MAIN_ATOMIC;
      pma_memtype_o = mpu_pkg::PMA_MAIN_MEMTYPE;
    end else if (hit_io) begin
      // Atomics rejected here
      pma_err_o     = atomic_i && !mpu_pkg::PMA_IO_ATOMIC;
      pma_memtype_o = mpu_pkg::PMA_IO_MEMTYPE;
    end else if (hit_buf) begin
      pma_err_o     = atomic_i && !mpu_pkg::PMA_BUF_ATOMIC;
      pma_memtype_o = mpu_pkg::PMA_BUF_MEMTYPE;
    end

    // Faulting access carries no attributes toward the bus
    if (pma_err_o) begin
      pma_memtype_o = 2'b00;
    end
  end

endmodule

`default_nettype wire

/* verilog/pmp_check.sv */
// PMP region match for data accesses
// TOR and NA4 matching, lowest entry wins, lock and privilege rules applied
`timescale 1ns/1ps
`default_nettype none

module pmp_check #(
  parameter int unsigned PMP_NUM_REGIONS = 4
) (
  input  wire  mpu_pkg::addr_t     addr_i,
  input  wire  mpu_pkg::pmp_req_e  req_type_i,
  input  wire  mpu_pkg::priv_lvl_e priv_lvl_i,
  input  wire  mpu_pkg::pmp_cfg_t  csr_pmp_cfg_i  [PMP_NUM_REGIONS],
  input  wire  mpu_pkg::pmp_addr_t csr_pmp_addr_i [PMP_NUM_REGIONS],
  output logic                     pmp_err_o
);

  mpu_pkg::pmp_addr_t         word_addr;
  logic                       is_mach;
  logic [PMP_NUM_REGIONS-1:0] region_match;
  logic [PMP_NUM_REGIONS-1:0] region_allow;

  // CSRs hold word addresses
  assign word_addr = {2'b00, addr_i[31:2]};
  assign is_mach   = (priv_lvl_i == mpu_pkg::PRIV_M);

  ////////////////////
  // Per-region match
  ////////////////////

  for (genvar i = 0; i < PMP_NUM_REGIONS; i++) begin : g_region
    mpu_pkg::pmp_addr_t lower;
    mpu_pkg::pmp_mode_e mode;
    logic               tor_hit;
    logic               na4_hit;
    logic               perm;
    logic               locked;

    // Entry 0 has zero as its TOR lower bound
    if (i == 0) begin : g_first
      assign lower = '0;
    end else begin : g_rest
      assign lower = csr_pmp_addr_i[i-1];
    end

    // Mode field is bits 4:3
    assign mode    = mpu_pkg::pmp_mode_e'(csr_pmp_cfg_i[i][4:3]);
    assign tor_hit = (word_addr >= lower) && (word_addr < csr_pmp_addr_i[i]);
    assign na4_hit = (word_addr == csr_pmp_addr_i[i]);

    // NAPOT and OFF never match
    assign region_match[i] = ((mode == mpu_pkg::PMP_TOR) && tor_hit) ||
                             ((mode == mpu_pkg::PMP_NA4) && na4_hit);

    // Permission bit for this access kind
    assign perm = (req_type_i == mpu_pkg::PMP_ACC_WRITE) ?
                  csr_pmp_cfg_i[i][mpu_pkg::PMP_CFG_W_BIT] :
                  csr_pmp_cfg_i[i][mpu_pkg::PMP_CFG_R_BIT];
    assign locked = csr_pmp_cfg_i[i][mpu_pkg::PMP_CFG_L_BIT];

    // M-mode bypasses unlocked entries, otherwise the bit decides
    assign region_allow[i] = (is_mach && !locked) || perm;
  end

  ////////////////////
  // Priority decision
  ////////////////////

  always_comb begin
    // No match: M allowed, U denied
    pmp_err_o = !is_mach;
    // Walk downward so the lowest matching entry is applied last
    for (int i = PMP_NUM_REGIONS - 1; i >= 0; i--) begin
      if (region_match[i]) begin
        pmp_err_o = !region_allow[i];
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/mpu.sv */
// Data-side memory protection unit
// Forwards passing transfers with memtype, consumes faults and answers them
// once earlier bus transactions have drained
`timescale 1ns/1ps
`default_nettype none

module mpu #(
  parameter int unsigned PMP_NUM_REGIONS = 4
) (
  input  wire                      clk,
  input  wire                      rst_n,
  // Core request
  input  wire                      core_trans_valid_i,
  output logic                     core_trans_ready_o,
  input  wire  mpu_pkg::addr_t     core_addr_i,
  input  wire                      core_we_i,
  input  wire  mpu_pkg::data_t     core_wdata_i,
  input  wire                      core_atomic_i,
  // Bus request
  output logic                     bus_trans_valid_o,
  input  wire                      bus_trans_ready_i,
  output mpu_pkg::addr_t           bus_addr_o,
  output logic                     bus_we_o,
  output mpu_pkg::data_t           bus_wdata_o,
  output mpu_pkg::memtype_t        bus_memtype_o,
  // Bus response
  input  wire                      bus_resp_valid_i,
  input  wire  mpu_pkg::data_t     bus_rdata_i,
  input  wire                      bus_err_i,
  // Core response
  output logic                     core_resp_valid_o,
  output mpu_pkg::data_t           core_rdata_o,
  output logic                     core_bus_err_o,
  output mpu_pkg::mpu_status_e     core_status_o,
  // CSRs and privilege
  input  wire  mpu_pkg::pmp_cfg_t  csr_pmp_cfg_i  [PMP_NUM_REGIONS],
  input  wire  mpu_pkg::pmp_addr_t csr_pmp_addr_i [PMP_NUM_REGIONS],
  input  wire  mpu_pkg::priv_lvl_e priv_lvl_i,
  // Next-cycle outstanding count is one
  input  wire                      one_txn_pend_n_i
);

  logic                 pma_err;
  logic                 pmp_err;
  logic                 mpu_err;
  mpu_pkg::memtype_t    pma_memtype;
  mpu_pkg::pmp_req_e    pmp_req_type;
  mpu_pkg::mpu_state_e  state_q;
  mpu_pkg::mpu_state_e  state_n;
  logic                 block_core;
  logic                 block_bus;
  logic                 fault_resp_valid;
  mpu_pkg::mpu_status_e fault_status;

  ////////////////////
  // Checkers
  ////////////////////

  pma_check u_pma_check (
    .addr_i        (core_addr_i),
    .atomic_i      (core_atomic_i),
    .pma_err_o     (pma_err),
    .pma_memtype_o (pma_memtype)
  );

  assign pmp_req_type = core_we_i ? mpu_pkg::PMP_ACC_WRITE : mpu_pkg::PMP_ACC_READ;

  pmp_check #(
    .PMP_NUM_REGIONS (PMP_NUM_REGIONS)
  ) u_pmp_check (
    .addr_i         (core_addr_i),
    .req_type_i     (pmp_req_type),
    .priv_lvl_i     (priv_lvl_i),
    .csr_pmp_cfg_i  (csr_pmp_cfg_i),
    .csr_pmp_addr_i (csr_pmp_addr_i),
    .pmp_err_o      (pmp_err)
  );

  assign mpu_err = pma_err || pmp_err;

  ////////////////////
  // Fault FSM
  ////////////////////

  always_comb begin
    state_n          = state_q;
    block_core       = 1'b0;
    block_bus        = 1'b0;
    fault_resp_valid = 1'b0;
    fault_status     = mpu_pkg::MPU_OK;

    case (state_q)
      mpu_pkg::MPU_IDLE: begin
        // A faulting request never shows as valid on the bus
        if (mpu_err && core_trans_valid_i) begin
          block_bus = 1'b1;
          // Fault taken only on a cycle the core handshake completes
          if (bus_trans_ready_i) begin
            if (core_we_i) begin
              state_n = one_txn_pend_n_i ? mpu_pkg::MPU_WR_ERR_RESP :
                                           mpu_pkg::MPU_WR_ERR_WAIT;
            end else begin
              state_n = one_txn_pend_n_i ? mpu_pkg::MPU_RE_ERR_RESP :
                                           mpu_pkg::MPU_RE_ERR_WAIT;
            end
          end
        end
      end
      mpu_pkg::MPU_RE_ERR_WAIT, mpu_pkg::MPU_WR_ERR_WAIT: begin
        // Hold everything off until only the faulting transfer remains
        block_core = 1'b1;
        block_bus  = 1'b1;
        if (one_txn_pend_n_i) begin
          state_n = (state_q == mpu_pkg::MPU_RE_ERR_WAIT) ?
                    mpu_pkg::MPU_RE_ERR_RESP : mpu_pkg::MPU_WR_ERR_RESP;
        end
      end
      mpu_pkg::MPU_RE_ERR_RESP, mpu_pkg::MPU_WR_ERR_RESP: begin
        block_core       = 1'b1;
        block_bus        = 1'b1;
        fault_resp_valid = 1'b1;
        fault_status     = (state_q == mpu_pkg::MPU_RE_ERR_RESP) ?
                           mpu_pkg::MPU_RE_FAULT : mpu_pkg::MPU_WR_FAULT;
        state_n          = mpu_pkg::MPU_IDLE;
      end
      default: state_n = mpu_pkg::MPU_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= mpu_pkg::MPU_IDLE;
    end else begin
      state_q <= state_n;
    end
  end

  ////////////////////
  // Forwarding
  ////////////////////

  assign core_trans_ready_o = bus_trans_ready_i && !block_core;
  assign bus_trans_valid_o  = core_trans_valid_i && !block_bus;
  assign bus_addr_o         = core_addr_i;
  assign bus_we_o           = core_we_i;
  assign bus_wdata_o        = core_wdata_i;
  assign bus_memtype_o      = pma_memtype;

  // Response mux, bus and fault strobes are exclusive
  assign core_resp_valid_o = bus_resp_valid_i || fault_resp_valid;
  assign core_rdata_o      = bus_resp_valid_i ? bus_rdata_i : '0;
  assign core_bus_err_o    = bus_resp_valid_i && bus_err_i;
  assign core_status_o     = fault_status;

  // A fault answer must never collide with a drained bus response
  a_resp_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
    !(bus_resp_valid_i && fault_resp_valid))
    else $error("bus and fault response in the same cycle");

  // Bus stays quiet while a fault is being handled
  a_bus_blocked: assert property (@(posedge clk) disable iff (!rst_n)
    (state_q != mpu_pkg::MPU_IDLE) |-> !bus_trans_valid_o)
    else $error("bus request outside MPU_IDLE");

endmodule

`default_nettype wire

/* verilog/txn_tracker.sv */
// Outstanding transaction counter
// Flags when the count for the next cycle is exactly one
`timescale 1ns/1ps
`default_nettype none

module txn_tracker (
  input  wire  clk,
  input  wire  rst_n,
  input  wire  core_accept_i,
  input  wire  core_resp_valid_i,
  output logic one_txn_pend_n_o
);

  // Wide enough for any backlog the bus can build
  localparam int unsigned CNT_W = 8;

  logic [CNT_W-1:0] cnt_q;
  logic [CNT_W-1:0] cnt_n;

  ////////////////////
  // Next count
  ////////////////////

  always_comb begin
    cnt_n = cnt_q;
    // Accept and response in one cycle cancel out
    case ({core_accept_i, core_resp_valid_i})
      2'b10:   cnt_n = cnt_q + 1'b1;
      2'b01:   cnt_n = cnt_q - 1'b1;
      default: cnt_n = cnt_q;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_n;
    end
  end

  // Looks one cycle ahead
  assign one_txn_pend_n_o = (cnt_n == CNT_W'(1));

  // Every response belongs to a transfer accepted in an earlier cycle
  a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
    core_resp_valid_i |-> (cnt_q != '0))
    else $error("response with no outstanding transaction");

endmodule

`default_nettype wire

/* verilog/lsu_mpu_top.sv */
// Load/store protection top level
// Joins the MPU with its outstanding transaction tracker
`timescale 1ns/1ps
`default_nettype none

module lsu_mpu_top #(
  parameter int unsigned PMP_NUM_REGIONS = 4
) (
  input  wire                      clk,
  input  wire                      rst_n,
  input  wire                      core_trans_valid_i,
  output logic                     core_trans_ready_o,
  input  wire  mpu_pkg::addr_t     core_addr_i,
  input  wire                      core_we_i,
  input  wire  mpu_pkg::data_t     core_wdata_i,
  input  wire                      core_atomic_i,
  output logic                     bus_trans_valid_o,
  input  wire                      bus_trans_ready_i,
  output mpu_pkg::addr_t           bus_addr_o,
  output logic                     bus_we_o,
  output mpu_pkg::data_t           bus_wdata_o,
  output mpu_pkg::memtype_t        bus_memtype_o,
  input  wire                      bus_resp_valid_i,
  input  wire  mpu_pkg::data_t     bus_rdata_i,
  input  wire                      bus_err_i,
  output logic                     core_resp_valid_o,
  output mpu_pkg::data_t           core_rdata_o,
  output logic                     core_bus_err_o,
  output mpu_pkg::mpu_status_e     core_status_o,
  input  wire  mpu_pkg::pmp_cfg_t  csr_pmp_cfg_i  [PMP_NUM_REGIONS],
  input  wire  mpu_pkg::pmp_addr_t csr_pmp_addr_i [PMP_NUM_REGIONS],
  input  wire  mpu_pkg::priv_lvl_e priv_lvl_i
);

  logic core_accept;
  logic one_txn_pend_n;

  // Core handshake, faulting transfers count too
  assign core_accept = core_trans_valid_i && core_trans_ready_o;

  mpu #(
    .PMP_NUM_REGIONS (PMP_NUM_REGIONS)
  ) u_mpu (
    .clk, .rst_n,
    .core_trans_valid_i, .core_trans_ready_o, .core_addr_i,
    .core_we_i, .core_wdata_i, .core_atomic_i,
    .bus_trans_valid_o, .bus_trans_ready_i, .bus_addr_o,
    .bus_we_o, .bus_wdata_o, .bus_memtype_o,
    .bus_resp_valid_i, .bus_rdata_i, .bus_err_i,
    .core_resp_valid_o, .core_rdata_o, .core_bus_err_o, .core_status_o,
    .csr_pmp_cfg_i, .csr_pmp_addr_i, .priv_lvl_i,
    .one_txn_pend_n_i (one_txn_pend_n)
  );

  txn_tracker u_txn_tracker (
    .clk               (clk),
    .rst_n             (rst_n),
    .core_accept_i     (core_accept),
    .core_resp_valid_i (core_resp_valid_o),
    .one_txn_pend_n_o  (one_txn_pend_n)
  );

endmodule

`default_nettype wire

/* bench/tb_lsu_mpu.sv */
// Testbench for the load/store protection top level
// Random core traffic against a bus responder, checked by a PMA/PMP model
`timescale 1ns/1ps
`default_nettype none

module tb_lsu_mpu;

  localparam int unsigned PMP_N      = 4;
  localparam int unsigned NUM_RANDOM = 2000;

  logic                 clk = 1'b0;
  logic                 rst_n;
  logic                 core_trans_valid_i;
  logic                 core_trans_ready_o;
  mpu_pkg::addr_t       core_addr_i;
  logic                 core_we_i;
  mpu_pkg::data_t       core_wdata_i;
  logic                 core_atomic_i;
  logic                 bus_trans_valid_o;
  logic                 bus_trans_ready_i;
  mpu_pkg::addr_t       bus_addr_o;
  logic                 bus_we_o;
  mpu_pkg::data_t       bus_wdata_o;
  mpu_pkg::memtype_t    bus_memtype_o;
  logic                 bus_resp_valid_i;
  mpu_pkg::data_t       bus_rdata_i;
  logic                 bus_err_i;
  logic                 core_resp_valid_o;
  mpu_pkg::data_t       core_rdata_o;
  logic                 core_bus_err_o;
  mpu_pkg::mpu_status_e core_status_o;
  mpu_pkg::pmp_cfg_t    pmp_cfg  [PMP_N];
  mpu_pkg::pmp_addr_t   pmp_addr [PMP_N];
  mpu_pkg::priv_lvl_e   priv_lvl_i;

  integer               seed = 32'h23b1_e48b;
  int unsigned          cyc;
  int unsigned          accepted;
  int unsigned          fault_cnt;
  bit                   random_mode;
  bit                   req_held;
  // Directed request waiting for the core to be free
  bit                   dir_pending;
  mpu_pkg::addr_t       dir_addr;
  logic                 dir_we;
  logic                 dir_atomic;
  mpu_pkg::priv_lvl_e   dir_priv;
  // Model state: expected responses in order, bus response due cycles
  mpu_pkg::mpu_status_e exp_q [$];
  int unsigned          bus_due_q [$];
  bit                   blocked;
  bit                   fault_due_set;
  int unsigned          fault_due;

  always #4 clk = ~clk;

  lsu_mpu_top #(
    .PMP_NUM_REGIONS (PMP_N)
  ) uut (
    .clk, .rst_n,
    .core_trans_valid_i, .core_trans_ready_o, .core_addr_i,
    .core_we_i, .core_wdata_i, .core_atomic_i,
    .bus_trans_valid_o, .bus_trans_ready_i, .bus_addr_o,
    .bus_we_o, .bus_wdata_o, .bus_memtype_o,
    .bus_resp_valid_i, .bus_rdata_i, .bus_err_i,
    .core_resp_valid_o, .core_rdata_o, .core_bus_err_o, .core_status_o,
    .csr_pmp_cfg_i  (pmp_cfg),
    .csr_pmp_addr_i (pmp_addr),
    .priv_lvl_i
  );

  ////////////////////
  // Helpers
  ////////////////////

  task automatic report_failure(input string why);
    $display("%s", why);
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected) begin
      report_failure($sformatf("FAIL %s: got 0x%08h, expected 0x%08h", name, got, expected));
    end
  endtask

  function automatic int unsigned rand_below(input int unsigned n);
    int unsigned r;
    r = $random(seed);
    return r % n;
  endfunction

  // Region table, returns {error, memtype}
  function automatic logic [2:0] pma_lookup(input mpu_pkg::addr_t addr, input logic atomic);
    if (addr < 32'h0001_0000) begin
      return {1'b0, 2'b11};
    end
    if (addr >= 32'h1000_0000 && addr < 32'h1000_1000) begin
      return {atomic, 2'b00};
    end
    if (addr >= 32'h2000_0000 && addr < 32'h2000_1000) begin
      return {atomic, 2'b01};
    end
    return 3'b100;
  endfunction

  // Lowest matching entry decides, no match denies user mode only
  function automatic logic pmp_denied(input mpu_pkg::addr_t addr, input logic we,
                                      input mpu_pkg::priv_lvl_e priv);
    logic [31:0] word;
    logic [31:0] lower;
    logic [1:0]  mode;
    logic        hit;
    logic        perm;
    logic        found;
    logic        denied;
    word   = {2'b00, addr[31:2]};
    lower  = 32'd0;
    found  = 1'b0;
    denied = (priv != mpu_pkg::PRIV_M);
    for (int i = 0; i < PMP_N; i++) begin
      mode = pmp_cfg[i][4:3];
      hit  = (mode == 2'b01 && word >= lower && word < pmp_addr[i]) ||
             (mode == 2'b10 && word == pmp_addr[i]);
      if (hit && !found) begin
        found = 1'b1;
        perm  = we ? pmp_cfg[i][1] : pmp_cfg[i][0];
        // Unlocked entries do not restrict machine mode
        if (priv == mpu_pkg::PRIV_M && !pmp_cfg[i][7]) begin
          denied = 1'b0;
        end else begin
          denied = !perm;
        end
      end
      lower = pmp_addr[i];
    end
    return denied;
  endfunction

  // Targets weighted toward region edges and the NA4 word
  task automatic pick_request();
    case (rand_below(8))
      0, 1:    core_addr_i = rand_below(32'h0001_0000);
      2:       core_addr_i = 32'h1000_0000 + rand_below(32'h1000);
      3:       core_addr_i = 32'h1000_0000 + rand_below(32'h20);
      4:       core_addr_i = 32'h2000_0000 + rand_below(32'h1000);
      5:       core_addr_i = $random(seed);
      6:       core_addr_i = rand_below(32'h2000);
      default: core_addr_i = 32'h2000_0000 + rand_below(32'h1000);
    endcase
    core_we_i     = (rand_below(2) == 1);
    core_wdata_i  = $random(seed);
    core_atomic_i = (rand_below(8) == 0);
    priv_lvl_i    = (rand_below(2) == 1) ? mpu_pkg::PRIV_M : mpu_pkg::PRIV_U;
  endtask

  ////////////////////
  // One clock cycle
  ////////////////////

  task automatic step_cycle();
    logic [2:0] pma;
    logic       fault_now;
    logic       bus_resp;
    logic       exp_valid;
    logic       exp_resp;
    @(negedge clk);
    cyc++;
    // Core holds its request until accepted
    if (!req_held) begin
      if (dir_pending) begin
        core_addr_i   = dir_addr;
        core_we_i     = dir_we;
        core_wdata_i  = $random(seed);
        core_atomic_i = dir_atomic;
        priv_lvl_i    = dir_priv;
        req_held      = 1'b1;
        dir_pending   = 1'b0;
      end else if (random_mode && rand_below(4) != 0) begin
        pick_request();
        req_held = 1'b1;
      end
    end
    core_trans_valid_i = req_held;
    // Bus responder, in order, one strobe per cycle
    bus_trans_ready_i = (rand_below(4) != 0);
    bus_resp          = (bus_due_q.size() != 0) && (bus_due_q[0] <= cyc);
    bus_resp_valid_i  = bus_resp;
    bus_rdata_i       = $random(seed);
    bus_err_i         = (rand_below(8) == 0);
    // Settle before the rising edge
    #2;
    pma       = pma_lookup(core_addr_i, core_atomic_i);
    fault_now = pma[2] || pmp_denied(core_addr_i, core_we_i, priv_lvl_i);

    check_value("core_trans_ready_o", 32'(core_trans_ready_o),
                32'(bus_trans_ready_i && !blocked));
    // Faulting or blocked requests never show on the bus
    exp_valid = core_trans_valid_i && !blocked && !fault_now;
    check_value("bus_trans_valid_o", 32'(bus_trans_valid_o), 32'(exp_valid));
    if (exp_valid) begin
      check_value("bus_addr_o", bus_addr_o, core_addr_i);
      check_value("bus_we_o", 32'(bus_we_o), 32'(core_we_i));
      check_value("bus_wdata_o", bus_wdata_o, core_wdata_i);
      check_value("bus_memtype_o", 32'(bus_memtype_o), 32'(pma[1:0]));
    end

    // Response side
    exp_resp = bus_resp || (blocked && fault_due_set && fault_due == cyc);
    check_value("core_resp_valid_o", 32'(core_resp_valid_o), 32'(exp_resp));
    if (bus_resp) begin
      if (exp_q.size() == 0 || exp_q[0] != mpu_pkg::MPU_OK) begin
        report_failure("bus response arrived with no passing transfer at the queue head");
      end
      check_value("core_rdata_o", core_rdata_o, bus_rdata_i);
      check_value("core_bus_err_o", 32'(core_bus_err_o), 32'(bus_err_i));
      check_value("core_status_o", 32'(core_status_o), 32'(mpu_pkg::MPU_OK));
      void'(exp_q.pop_front());
      void'(bus_due_q.pop_front());
      // Last earlier response drained, fault answers next cycle
      if (blocked && !fault_due_set && bus_due_q.size() == 0) begin
        fault_due     = cyc + 1;
        fault_due_set = 1'b1;
      end
    end else if (exp_resp) begin
      check_value("core_status_o", 32'(core_status_o), 32'(exp_q[0]));
      void'(exp_q.pop_front());
      blocked       = 1'b0;
      fault_due_set = 1'b0;
    end

    // Core handshake at the coming edge
    if (core_trans_valid_i && core_trans_ready_o) begin
      req_held = 1'b0;
      accepted++;
      if (fault_now) begin
        exp_q.push_back(core_we_i ? mpu_pkg::MPU_WR_FAULT : mpu_pkg::MPU_RE_FAULT);
        fault_cnt++;
        blocked       = 1'b1;
        fault_due     = cyc + 1;
        fault_due_set = (bus_due_q.size() == 0);
      end else begin
        exp_q.push_back(mpu_pkg::MPU_OK);
        bus_due_q.push_back(cyc + 1 + rand_below(4));
      end
    end
  endtask

  task automatic drain_responses(input int unsigned limit);
    int unsigned guard;
    guard = 0;
    while (exp_q.size() != 0 || req_held || dir_pending) begin
      step_cycle();
      guard++;
      if (guard > limit) begin
        report_failure("timeout waiting for outstanding transfers to complete");
      end
    end
  endtask

  // Single transfer issued on an idle path
  task automatic run_directed(input mpu_pkg::addr_t addr, input logic we,
                              input logic atomic, input mpu_pkg::priv_lvl_e priv);
    dir_addr    = addr;
    dir_we      = we;
    dir_atomic  = atomic;
    dir_priv    = priv;
    dir_pending = 1'b1;
    drain_responses(200);
  endtask

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    int unsigned guard;
    rst_n              = 1'b0;
    core_trans_valid_i = 1'b0;
    core_addr_i        = '0;
    core_we_i          = 1'b0;
    core_wdata_i       = '0;
    core_atomic_i      = 1'b0;
    bus_trans_ready_i  = 1'b0;
    bus_resp_valid_i   = 1'b0;
    bus_rdata_i        = '0;
    bus_err_i          = 1'b0;
    priv_lvl_i         = mpu_pkg::PRIV_M;
    // Locked read-only TOR, open TOR, write-only NA4, read-only TOR
    pmp_cfg[0]  = 8'h89;
    pmp_addr[0] = 32'h0000_0800;
    pmp_cfg[1]  = 8'h0B;
    pmp_addr[1] = 32'h0000_2000;
    pmp_cfg[2]  = 8'h12;
    pmp_addr[2] = 32'h0400_0004;
    pmp_cfg[3]  = 8'h09;
    pmp_addr[3] = 32'h0800_0200;
    cyc           = 0;
    accepted      = 0;
    fault_cnt     = 0;
    random_mode   = 1'b0;
    req_held      = 1'b0;
    dir_pending   = 1'b0;
    blocked       = 1'b0;
    fault_due_set = 1'b0;
    fault_due     = 0;

    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // Idle path, ready follows the bus
    repeat (16) step_cycle();

    // One of each pass and fault kind
    run_directed(32'h0000_4000, 1'b0, 1'b0, mpu_pkg::PRIV_M);
    run_directed(32'h1000_0004, 1'b1, 1'b0, mpu_pkg::PRIV_M);
    run_directed(32'h2000_0100, 1'b0, 1'b0, mpu_pkg::PRIV_U);
    run_directed(32'h3000_0000, 1'b0, 1'b0, mpu_pkg::PRIV_M);
    run_directed(32'h1000_0020, 1'b1, 1'b1, mpu_pkg::PRIV_M);
    run_directed(32'h2000_0040, 1'b0, 1'b1, mpu_pkg::PRIV_M);
    run_directed(32'h2000_0100, 1'b1, 1'b0, mpu_pkg::PRIV_U);
    run_directed(32'h1000_0010, 1'b0, 1'b0, mpu_pkg::PRIV_U);
    run_directed(32'h1000_0012, 1'b1, 1'b0, mpu_pkg::PRIV_U);
    run_directed(32'h0000_9000, 1'b0, 1'b0, mpu_pkg::PRIV_U);
    run_directed(32'h0000_0100, 1'b1, 1'b0, mpu_pkg::PRIV_M);
    run_directed(32'h0000_0100, 1'b0, 1'b0, mpu_pkg::PRIV_M);
    run_directed(32'h0000_3000, 1'b1, 1'b0, mpu_pkg::PRIV_U);

    // Random traffic with back-pressure
    accepted    = 0;
    random_mode = 1'b1;
    guard       = 0;
    while (accepted < NUM_RANDOM) begin
      step_cycle();
      guard++;
      if (guard > 60000) begin
        report_failure("timeout before all random transfers were accepted");
      end
    end
    random_mode = 1'b0;
    drain_responses(500);

    $display("Random transfers %0d, faults %0d, cycles %0d", accepted, fault_cnt, cyc);
    $display("Testbench passed");
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
verilog/mpu_pkg.sv
verilog/pma_check.sv
verilog/pmp_check.sv
verilog/mpu.sv
verilog/txn_tracker.sv
verilog/lsu_mpu_top.sv
bench/tb_lsu_mpu.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the LSU MPU testbench with Verilator
set -e
cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert --top-module tb_lsu_mpu -f sources.f -o sim_lsu_mpu

# The log decides the result, not the exit status of the run
./obj_dir/sim_lsu_mpu > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "Testbench failed" "$LOG"; then
  echo "Simulation FAILED"
  exit 1
fi
if ! grep -q "Testbench passed" "$LOG"; then
  echo "Simulation ended without a result"
  exit 1
fi
echo "Simulation PASSED"
